// File: include/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// cache organisation
`define DCACHE_WAYS 4
`define DCACHE_SETS 64
`define DCACHE_BANKS 4

// two independent load pipes
`define DCACHE_LOAD_PORTS 2

// physical address and data word widths
`define DCACHE_PADDR_W 32
`define DCACHE_WORD_W 32

`endif

// File: logic/dcache_arrays.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module dcache_arrays (
    input  logic clk,
    input  logic rst,
    input  dcache_geom_pkg::set_idx_t [`DCACHE_LOAD_PORTS-1:0] tag_rd_idx,
    input  dcache_geom_pkg::set_idx_t st_tag_rd_idx,
    input  dcache_geom_pkg::set_idx_t [`DCACHE_BANKS-1:0] bank_rd_idx,
    input  dcache_msg_pkg::array_wr_t wr,
    output dcache_geom_pkg::tagv_t [`DCACHE_LOAD_PORTS-1:0][`DCACHE_WAYS-1:0] tagv_rd,
    output dcache_geom_pkg::tagv_t [`DCACHE_WAYS-1:0] st_tagv_rd,
    output dcache_geom_pkg::word_t [`DCACHE_BANKS-1:0][`DCACHE_WAYS-1:0] data_rd
);

    localparam int RD_PORTS = `DCACHE_LOAD_PORTS + 1;

    dcache_geom_pkg::tag_t tag_mem [`DCACHE_WAYS][`DCACHE_SETS];
    dcache_geom_pkg::word_t data_mem [`DCACHE_BANKS][`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_WAYS-1:0] valid_q [`DCACHE_SETS];

    dcache_geom_pkg::set_idx_t [RD_PORTS-1:0] rd_idx;
    dcache_geom_pkg::tagv_t [RD_PORTS-1:0][`DCACHE_WAYS-1:0] tagv_q;

    // store lookup uses the last tag read port
    always_comb begin
        rd_idx[RD_PORTS-1] = st_tag_rd_idx;
        for (int p = 0; p < `DCACHE_LOAD_PORTS; p++) begin
            rd_idx[p] = tag_rd_idx[p];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            valid_q[wr.set] <= valid_q[wr.set] | wr.tag_we;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (wr.tag_we[w]) begin
                tag_mem[w][wr.set] <= wr.tag;
            end
        end
    end

    // byte-granular write into each bank
    always_ff @(posedge clk) begin
        for (int b = 0; b < `DCACHE_BANKS; b++) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                for (int k = 0; k < dcache_geom_pkg::WORD_BYTES; k++) begin
                    if (wr.data_we[w] && wr.byte_en[b][k]) begin
                        data_mem[b][w][wr.set][8*k +: 8] <= wr.line[b][8*k +: 8];
                    end
                end
            end
        end
    end

    // registered reads see the contents before this cycle's write
    always_ff @(posedge clk) begin
        for (int r = 0; r < RD_PORTS; r++) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                tagv_q[r][w].valid <= valid_q[rd_idx[r]][w];
                tagv_q[r][w].tag <= tag_mem[w][rd_idx[r]];
            end
        end
        for (int b = 0; b < `DCACHE_BANKS; b++) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                data_rd[b][w] <= data_mem[b][w][bank_rd_idx[b]];
            end
        end
    end

    assign tagv_rd = tagv_q[`DCACHE_LOAD_PORTS-1:0];
    assign st_tagv_rd = tagv_q[RD_PORTS-1];

endmodule

// File: logic/dcache_geom_pkg.sv
`include "dcache_defines.svh"

package dcache_geom_pkg;

    localparam int WAY_W = $clog2(`DCACHE_WAYS);
    localparam int SET_W = $clog2(`DCACHE_SETS);
    localparam int BANK_W = $clog2(`DCACHE_BANKS);
    localparam int WORD_BYTES = `DCACHE_WORD_W / 8;
    localparam int OFFS_W = $clog2(WORD_BYTES);
    localparam int TAG_W = `DCACHE_PADDR_W - SET_W - BANK_W - OFFS_W;

    typedef logic [SET_W-1:0] set_idx_t;
    typedef logic [BANK_W-1:0] bank_idx_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_WAYS-1:0] way_mask_t;
    typedef logic [WAY_W-1:0] way_idx_t;
    typedef logic [WORD_BYTES-1:0] byte_mask_t;
    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    // bank 0 holds the lowest word of the line
    typedef word_t [`DCACHE_BANKS-1:0] line_t;

    typedef struct packed {
        tag_t tag;
        set_idx_t set;
        bank_idx_t bank;
        logic [OFFS_W-1:0] offset;
    } paddr_t;

    // one way of the tag array as read out
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

endpackage

// File: logic/dcache_msg_pkg.sv
`include "dcache_defines.svh"

package dcache_msg_pkg;

    typedef struct packed {
        logic valid;
        dcache_geom_pkg::paddr_t paddr;
    } load_req_t;

    typedef struct packed {
        logic valid;
        logic hit;
        logic replay;
        dcache_geom_pkg::word_t data;
    } load_resp_t;

    typedef struct packed {
        logic valid;
        dcache_geom_pkg::paddr_t paddr;
        dcache_geom_pkg::word_t data;
        dcache_geom_pkg::byte_mask_t mask;
    } store_req_t;

    typedef struct packed {
        logic valid;
        logic hit;
        logic retry;
    } store_resp_t;

    typedef struct packed {
        logic valid;
        dcache_geom_pkg::paddr_t paddr;
        dcache_geom_pkg::way_idx_t way;
        dcache_geom_pkg::line_t line;
    } refill_t;

    typedef struct packed {
        logic valid;
        dcache_geom_pkg::paddr_t paddr;
        logic port;
    } miss_req_t;

    // arbiter to load pipe
    typedef struct packed {
        logic valid;
        logic replay;
        dcache_geom_pkg::paddr_t paddr;
    } load_issue_t;

    // load pipe to collector
    typedef struct packed {
        logic valid;
        logic replay;
        logic hit;
        dcache_geom_pkg::word_t data;
        dcache_geom_pkg::paddr_t paddr;
    } pipe_result_t;

    // single write port of the arrays, shared by refill and store
    typedef struct packed {
        dcache_geom_pkg::way_mask_t tag_we;
        dcache_geom_pkg::set_idx_t set;
        dcache_geom_pkg::tag_t tag;
        dcache_geom_pkg::way_mask_t data_we;
        dcache_geom_pkg::byte_mask_t [`DCACHE_BANKS-1:0] byte_en;
        dcache_geom_pkg::line_t line;
    } array_wr_t;

endpackage

// File: logic/dcache_top.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic clk,
    input  logic rst,
    input  dcache_msg_pkg::load_req_t [`DCACHE_LOAD_PORTS-1:0] load_req,
    output dcache_msg_pkg::load_resp_t [`DCACHE_LOAD_PORTS-1:0] load_resp,
    input  dcache_msg_pkg::store_req_t store_req,
    output dcache_msg_pkg::store_resp_t store_resp,
    input  dcache_msg_pkg::refill_t refill,
    output dcache_msg_pkg::miss_req_t miss_req
);

    dcache_msg_pkg::load_issue_t [`DCACHE_LOAD_PORTS-1:0] issue;
    dcache_msg_pkg::pipe_result_t [`DCACHE_LOAD_PORTS-1:0] results;
    dcache_msg_pkg::array_wr_t wr;
    dcache_geom_pkg::set_idx_t [`DCACHE_LOAD_PORTS-1:0] tag_rd_idx;
    dcache_geom_pkg::set_idx_t [`DCACHE_BANKS-1:0] bank_rd_idx;
    dcache_geom_pkg::set_idx_t st_tag_rd_idx;
    dcache_geom_pkg::tagv_t [`DCACHE_LOAD_PORTS-1:0][`DCACHE_WAYS-1:0] tagv_rd;
    dcache_geom_pkg::tagv_t [`DCACHE_WAYS-1:0] st_tagv_rd;
    dcache_geom_pkg::word_t [`DCACHE_BANKS-1:0][`DCACHE_WAYS-1:0] data_rd;
    logic write_active;

    load_bank_arbiter load_bank_arbiter_i (
        .clk(clk),
        .rst(rst),
        .load_req(load_req),
        .write_active(write_active),
        .issue(issue),
        .tag_rd_idx(tag_rd_idx),
        .bank_rd_idx(bank_rd_idx)
    );

    for (genvar p = 0; p < `DCACHE_LOAD_PORTS; p++) begin : g_pipe
        load_pipe load_pipe_i (
            .clk(clk),
            .rst(rst),
            .issue(issue[p]),
            .tagv_rd(tagv_rd[p]),
            .data_rd(data_rd),
            .result(results[p])
        );
    end

    load_result_collector load_result_collector_i (
        .clk(clk),
        .rst(rst),
        .results(results),
        .load_resp(load_resp),
        .miss_req(miss_req)
    );

    dcache_arrays dcache_arrays_i (
        .clk(clk),
        .rst(rst),
        .tag_rd_idx(tag_rd_idx),
        .st_tag_rd_idx(st_tag_rd_idx),
        .bank_rd_idx(bank_rd_idx),
        .wr(wr),
        .tagv_rd(tagv_rd),
        .st_tagv_rd(st_tagv_rd),
        .data_rd(data_rd)
    );

    store_refill_ctrl store_refill_ctrl_i (
        .clk(clk),
        .rst(rst),
        .store_req(store_req),
        .refill(refill),
        .st_tagv_rd(st_tagv_rd),
        .st_tag_rd_idx(st_tag_rd_idx),
        .wr(wr),
        .write_active(write_active),
        .store_resp(store_resp)
    );

endmodule

// File: logic/load_bank_arbiter.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module load_bank_arbiter (
    input  logic clk,
    input  logic rst,
    input  dcache_msg_pkg::load_req_t [`DCACHE_LOAD_PORTS-1:0] load_req,
    input  logic write_active,
    output dcache_msg_pkg::load_issue_t [`DCACHE_LOAD_PORTS-1:0] issue,
    output dcache_geom_pkg::set_idx_t [`DCACHE_LOAD_PORTS-1:0] tag_rd_idx,
    output dcache_geom_pkg::set_idx_t [`DCACHE_BANKS-1:0] bank_rd_idx
);

    logic [`DCACHE_LOAD_PORTS-1:0] cancel;
    logic [`DCACHE_LOAD_PORTS-1:0] accepted;

    // lower port wins a shared bank
    always_comb begin
        cancel = '0;
        for (int p = 1; p < `DCACHE_LOAD_PORTS; p++) begin
            for (int q = 0; q < p; q++) begin
                if (load_req[p].valid && load_req[q].valid &&
                    load_req[p].paddr.bank == load_req[q].paddr.bank) begin
                    cancel[p] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `DCACHE_LOAD_PORTS; p++) begin
            accepted[p] = load_req[p].valid & ~cancel[p];
            issue[p].valid = load_req[p].valid;
            // array write this cycle means stale read data
            issue[p].replay = cancel[p] | write_active;
            issue[p].paddr = load_req[p].paddr;
            tag_rd_idx[p] = load_req[p].paddr.set;
        end
    end

    // each bank reads the set of the load that owns it
    always_comb begin
        bank_rd_idx = '0;
        for (int b = 0; b < `DCACHE_BANKS; b++) begin
            for (int p = 0; p < `DCACHE_LOAD_PORTS; p++) begin
                if (accepted[p] && load_req[p].paddr.bank == dcache_geom_pkg::bank_idx_t'(b)) begin
                    bank_rd_idx[b] = load_req[p].paddr.set;
                end
            end
        end
    end

    // an accepted load must own the read index of its bank
    for (genvar p = 0; p < `DCACHE_LOAD_PORTS; p++) begin : g_chk
        a_bank_exclusive: assert property (@(posedge clk) disable iff (!rst)
            accepted[p] |-> bank_rd_idx[load_req[p].paddr.bank] == load_req[p].paddr.set);
    end

endmodule

// File: logic/load_pipe.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module load_pipe (
    input  logic clk,
    input  logic rst,
    input  dcache_msg_pkg::load_issue_t issue,
    input  dcache_geom_pkg::tagv_t [`DCACHE_WAYS-1:0] tagv_rd,
    input  dcache_geom_pkg::word_t [`DCACHE_BANKS-1:0][`DCACHE_WAYS-1:0] data_rd,
    output dcache_msg_pkg::pipe_result_t result
);

    dcache_msg_pkg::load_issue_t issue_q;
    dcache_msg_pkg::pipe_result_t res_q;
    logic issue_valid_q;
    logic res_valid_q;
    logic [`DCACHE_WAYS-1:0] hit_way;
    dcache_geom_pkg::way_idx_t hit_idx;
    logic hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            issue_valid_q <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= issue.valid;
            res_valid_q <= issue_valid_q;
        end
    end

    // tags and data arrive one cycle after the issue
    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_way[w] = tagv_rd[w].valid && tagv_rd[w].tag == issue_q.paddr.tag;
            if (hit_way[w]) begin
                hit_idx = hit_idx | dcache_geom_pkg::way_idx_t'(w);
            end
        end
        hit = |hit_way;
    end

    always_ff @(posedge clk) begin
        issue_q <= issue;
        res_q.valid <= issue_valid_q;
        res_q.replay <= issue_q.replay;
        res_q.hit <= hit & ~issue_q.replay;
        res_q.data <= data_rd[issue_q.paddr.bank][hit_idx];
        res_q.paddr <= issue_q.paddr;
    end

    always_comb begin
        result = res_q;
        result.valid = res_valid_q;
    end

    // encoder above relies on this
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst)
        issue_valid_q |-> $onehot0(hit_way));

endmodule

// File: logic/load_result_collector.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module load_result_collector (
    input  logic clk,
    input  logic rst,
    input  dcache_msg_pkg::pipe_result_t [`DCACHE_LOAD_PORTS-1:0] results,
    output dcache_msg_pkg::load_resp_t [`DCACHE_LOAD_PORTS-1:0] load_resp,
    output dcache_msg_pkg::miss_req_t miss_req
);

    logic [`DCACHE_LOAD_PORTS-1:0] miss;
    logic sel;
    logic found;

    // lowest missing port gets the single miss slot
    always_comb begin
        sel = 1'b0;
        found = 1'b0;
        for (int p = 0; p < `DCACHE_LOAD_PORTS; p++) begin
            miss[p] = results[p].valid & ~results[p].replay & ~results[p].hit;
            if (miss[p] && !found) begin
                sel = 1'(p);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `DCACHE_LOAD_PORTS; p++) begin
            load_resp[p].valid = results[p].valid;
            load_resp[p].hit = results[p].hit;
            load_resp[p].data = results[p].data;
            // losers of the miss slot come back as replay
            load_resp[p].replay = results[p].replay | (miss[p] & (sel != 1'(p)));
        end
        miss_req.valid = found;
        miss_req.paddr = results[sel].paddr;
        miss_req.port = sel;
    end

    // a replayed load never arrives from its pipe as a hit
    for (genvar p = 0; p < `DCACHE_LOAD_PORTS; p++) begin : g_chk
        a_miss_port_clean: assert property (@(posedge clk) disable iff (!rst)
            results[p].valid |-> !(results[p].hit && results[p].replay));
    end

endmodule

// File: logic/store_refill_ctrl.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module store_refill_ctrl (
    input  logic clk,
    input  logic rst,
    input  dcache_msg_pkg::store_req_t store_req,
    input  dcache_msg_pkg::refill_t refill,
    input  dcache_geom_pkg::tagv_t [`DCACHE_WAYS-1:0] st_tagv_rd,
    output dcache_geom_pkg::set_idx_t st_tag_rd_idx,
    output dcache_msg_pkg::array_wr_t wr,
    output logic write_active,
    output dcache_msg_pkg::store_resp_t store_resp
);

    dcache_msg_pkg::store_req_t st_q;
    logic st_valid_q;
    logic refill_seen_q;
    logic resp_valid_q;
    logic resp_hit_q;
    logic resp_retry_q;
    dcache_geom_pkg::way_mask_t st_way_hit;
    dcache_geom_pkg::way_mask_t refill_way;
    logic st_retry;
    logic st_we;

    assign st_tag_rd_idx = store_req.paddr.set;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            st_valid_q <= 1'b0;
            refill_seen_q <= 1'b0;
            resp_valid_q <= 1'b0;
            resp_hit_q <= 1'b0;
            resp_retry_q <= 1'b0;
        end else begin
            st_valid_q <= store_req.valid;
            refill_seen_q <= refill.valid;
            resp_valid_q <= st_valid_q;
            resp_hit_q <= st_we;
            resp_retry_q <= st_valid_q & st_retry;
        end
    end

    always_ff @(posedge clk) begin
        st_q <= store_req;
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            st_way_hit[w] = st_tagv_rd[w].valid && st_tagv_rd[w].tag == st_q.paddr.tag;
        end
    end

    // refill in either store cycle cancels the store
    assign st_retry = refill_seen_q | refill.valid;
    assign st_we = st_valid_q & ~st_retry & (|st_way_hit);
    assign refill_way = dcache_geom_pkg::way_mask_t'(1) << refill.way;

    // refill owns the write port whenever it strobes
    always_comb begin
        wr.tag = refill.paddr.tag;
        if (refill.valid) begin
            wr.tag_we = refill_way;
            wr.set = refill.paddr.set;
            wr.data_we = refill_way;
            wr.byte_en = '1;
            wr.line = refill.line;
        end else begin
            wr.tag_we = '0;
            wr.set = st_q.paddr.set;
            wr.data_we = st_we ? st_way_hit : '0;
            wr.line = {`DCACHE_BANKS{st_q.data}};
            for (int b = 0; b < `DCACHE_BANKS; b++) begin
                wr.byte_en[b] = (st_q.paddr.bank == dcache_geom_pkg::bank_idx_t'(b)) ?
                                st_q.mask : '0;
            end
        end
    end

    assign write_active = refill.valid | st_we;

    assign store_resp.valid = resp_valid_q;
    assign store_resp.hit = resp_hit_q;
    assign store_resp.retry = resp_retry_q;

    a_store_way_onehot: assert property (@(posedge clk) disable iff (!rst)
        st_we |-> $onehot0(wr.data_we));

endmodule

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module dcache_tb -f verilog.f || exit 1

out=$(./obj_dir/Vdcache_tb)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

// File: sim/dcache_tb.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module dcache_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS = 6;
    localparam int TEST_LEN = 160;
    localparam int DRAIN = 3;
    localparam int LIMIT_CYCLES = 2 + NUM_TESTS * (TEST_LEN + DRAIN) + 50;

    typedef struct packed {
        dcache_msg_pkg::load_req_t [`DCACHE_LOAD_PORTS-1:0] ld;
        dcache_msg_pkg::store_req_t st;
        dcache_msg_pkg::refill_t rf;
    } stim_t;

    typedef struct packed {
        logic [31:0] due;
        dcache_msg_pkg::load_resp_t [`DCACHE_LOAD_PORTS-1:0] resp;
        dcache_msg_pkg::miss_req_t miss;
    } load_exp_t;

    typedef struct packed {
        logic [31:0] due;
        dcache_msg_pkg::store_resp_t resp;
    } store_exp_t;

    logic clk;
    logic rst;
    dcache_msg_pkg::load_req_t [`DCACHE_LOAD_PORTS-1:0] load_req;
    dcache_msg_pkg::load_resp_t [`DCACHE_LOAD_PORTS-1:0] load_resp;
    dcache_msg_pkg::store_req_t store_req;
    dcache_msg_pkg::store_resp_t store_resp;
    dcache_msg_pkg::refill_t refill;
    dcache_msg_pkg::miss_req_t miss_req;

    load_exp_t load_q [$];
    store_exp_t store_q [$];
    logic [31:0] rng;
    logic [31:0] cycle;
    dcache_msg_pkg::store_req_t st_prev;
    logic refill_prev;
    int test_errors;
    int tests_passed;
    int tests_failed;
    string test_name;

    dcache_top dcache_top_i (
        .clk(clk),
        .rst(rst),
        .load_req(load_req),
        .load_resp(load_resp),
        .store_req(store_req),
        .store_resp(store_resp),
        .refill(refill),
        .miss_req(miss_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", LIMIT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = dcache_tb_model_pkg::xorshift32(rng);
        return rng;
    endfunction

    // small tag and set pool, upper tags never refilled
    function automatic dcache_geom_pkg::paddr_t pick_addr(input logic far);
        logic [31:0] r;
        dcache_geom_pkg::paddr_t a;
        r = next_rand();
        a.tag = dcache_geom_pkg::tag_t'({far, r[2:0]});
        a.set = {r[5:4], 2'b00, r[3], 1'b1};
        a.bank = r[7:6];
        a.offset = r[9:8];
        return a;
    endfunction

    function automatic stim_t make_stim(input int mode);
        stim_t s;
        logic [31:0] r;
        logic [`DCACHE_LOAD_PORTS-1:0] ld_on;
        logic rf_on;
        logic st_on;
        int w;
        s = '0;
        r = next_rand();
        rf_on = 1'b0;
        st_on = 1'b0;
        case (mode)
            0: ld_on = r[1:0];
            1: begin
                ld_on = r[1:0] | r[3:2];
                rf_on = (r[5:4] == 2'd0);
            end
            2: begin
                ld_on = 2'b11;
                rf_on = (r[5:3] == 3'd0);
            end
            3: begin
                ld_on = r[1:0];
                st_on = r[4];
            end
            4: begin
                ld_on = 2'b11;
                rf_on = r[5];
                st_on = r[4];
            end
            default: ld_on = 2'b11;
        endcase
        for (int p = 0; p < `DCACHE_LOAD_PORTS; p++) begin
            s.ld[p].valid = ld_on[p];
            s.ld[p].paddr = pick_addr(mode == 5);
        end
        if (mode == 2 && r[6]) begin
            s.ld[1].paddr.bank = s.ld[0].paddr.bank;
        end else if (mode == 2 || mode == 5) begin
            s.ld[1].paddr.bank = s.ld[0].paddr.bank + 2'd1;
        end
        if (rf_on) begin
            s.rf.valid = 1'b1;
            s.rf.paddr = pick_addr(1'b0);
            // a resident tag is refilled in place
            w = dcache_tb_model_pkg::find_way(s.rf.paddr.set, s.rf.paddr.tag);
            s.rf.way = (w >= 0) ? dcache_geom_pkg::way_idx_t'(w) : r[17:16];
            for (int b = 0; b < `DCACHE_BANKS; b++) begin
                s.rf.line[b] = next_rand();
            end
        end
        if (st_on) begin
            s.st.valid = 1'b1;
            s.st.paddr = pick_addr(r[20] & r[21]);
            s.st.data = next_rand();
            s.st.mask = (r[25:22] == 4'd0) ? 4'hf : r[25:22];
        end
        return s;
    endfunction

    function automatic string name_of(input int t);
        string n;
        case (t)
            0: n = "reset_state";
            1: n = "refill_then_load";
            2: n = "bank_conflict";
            3: n = "store_write_hit";
            4: n = "write_collision";
            default: n = "miss_arbitration";
        endcase
        return n;
    endfunction

    task automatic expect_equal(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
        assert (exp === act) else begin
            $display("[FAIL] %s %s cycle %0d expected %h actual %h",
                     test_name, what, cycle, exp, act);
            test_errors++;
        end
    endtask

    task automatic compare_outputs();
        load_exp_t le;
        store_exp_t se;
        dcache_msg_pkg::load_resp_t lr;
        dcache_msg_pkg::miss_req_t mr;
        le = '0;
        se = '0;
        if (load_q.size() > 0 && load_q[0].due == cycle) begin
            le = load_q.pop_front();
        end
        if (store_q.size() > 0 && store_q[0].due == cycle) begin
            se = store_q.pop_front();
        end
        for (int p = 0; p < `DCACHE_LOAD_PORTS; p++) begin
            lr = load_resp[p];
            // data only means something on a hit
            if (!le.resp[p].hit) begin
                lr.data = '0;
            end
            if (!le.resp[p].valid) begin
                lr.hit = 1'b0;
                lr.replay = 1'b0;
            end
            expect_equal($sformatf("load_resp[%0d]", p), 64'(le.resp[p]), 64'(lr));
        end
        mr = miss_req;
        if (!le.miss.valid) begin
            mr.paddr = '0;
            mr.port = 1'b0;
        end
        expect_equal("miss_req", 64'(le.miss), 64'(mr));
        expect_equal("store_resp", 64'(se.resp), 64'(store_resp));
    endtask

    task automatic run_cycle(input stim_t s);
        load_exp_t le;
        store_exp_t se;
        int st_way;
        int way;
        logic wr_active;
        logic cancel;
        logic miss;
        compare_outputs();
        load_req = s.ld;
        store_req = s.st;
        refill = s.rf;
        se = '0;
        se.due = cycle + 32'd1;
        st_way = -1;
        // store issued last cycle resolves now
        if (st_prev.valid) begin
            st_way = dcache_tb_model_pkg::find_way(st_prev.paddr.set, st_prev.paddr.tag);
            se.resp.valid = 1'b1;
            se.resp.retry = refill_prev | s.rf.valid;
            se.resp.hit = !se.resp.retry && st_way >= 0;
        end
        wr_active = se.resp.hit | s.rf.valid;
        le = '0;
        le.due = cycle + 32'd2;
        for (int p = 0; p < `DCACHE_LOAD_PORTS; p++) begin
            cancel = 1'b0;
            for (int q = 0; q < p; q++) begin
                if (s.ld[q].valid && s.ld[q].paddr.bank == s.ld[p].paddr.bank) begin
                    cancel = 1'b1;
                end
            end
            way = dcache_tb_model_pkg::find_way(s.ld[p].paddr.set, s.ld[p].paddr.tag);
            le.resp[p].valid = s.ld[p].valid;
            le.resp[p].replay = s.ld[p].valid & (cancel | wr_active);
            le.resp[p].hit = s.ld[p].valid & ~le.resp[p].replay & (way >= 0);
            if (le.resp[p].hit) begin
                le.resp[p].data = dcache_tb_model_pkg::read_word(s.ld[p].paddr.set, way,
                                                                 s.ld[p].paddr.bank);
            end
            miss = s.ld[p].valid & ~le.resp[p].replay & ~le.resp[p].hit;
            // one miss leaves per cycle
            if (miss && le.miss.valid) begin
                le.resp[p].replay = 1'b1;
            end else if (miss) begin
                le.miss.valid = 1'b1;
                le.miss.paddr = s.ld[p].paddr;
                le.miss.port = 1'(p);
            end
        end
        // reads above saw the old contents
        if (s.rf.valid) begin
            dcache_tb_model_pkg::fill_line(s.rf.paddr.set, int'(s.rf.way), s.rf.paddr.tag,
                                           s.rf.line);
        end else if (se.resp.hit) begin
            dcache_tb_model_pkg::merge_bytes(st_prev.paddr.set, st_way, st_prev.paddr.bank,
                                             st_prev.data, st_prev.mask);
        end
        load_q.push_back(le);
        store_q.push_back(se);
        st_prev = s.st;
        refill_prev = s.rf.valid;
        @(negedge clk);
        cycle = cycle + 32'd1;
    endtask

    initial begin
        stim_t idle;
        idle = '0;
        rst = 1'b0;
        load_req = '0;
        store_req = '0;
        refill = '0;
        rng = 32'd98865;
        cycle = '0;
        st_prev = '0;
        refill_prev = 1'b0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name = name_of(0);
        dcache_tb_model_pkg::clear();
        // nothing may come out while in reset
        repeat (2) begin
            @(negedge clk);
            compare_outputs();
        end
        rst = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_name = name_of(t);
            for (int i = 0; i < TEST_LEN; i++) begin
                run_cycle(make_stim(t));
            end
            repeat (DRAIN) run_cycle(idle);
            if (test_errors == 0) begin
                $display("test %s passed", test_name);
                tests_passed++;
            end else begin
                $display("test %s failed with %0d errors", test_name, test_errors);
                tests_failed++;
            end
            test_errors = 0;
        end
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/dcache_tb_model_pkg.sv
`include "dcache_defines.svh"

package dcache_tb_model_pkg;

    dcache_geom_pkg::tag_t line_tag [`DCACHE_SETS][`DCACHE_WAYS];
    logic line_valid [`DCACHE_SETS][`DCACHE_WAYS];
    dcache_geom_pkg::line_t line_data [`DCACHE_SETS][`DCACHE_WAYS];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void clear();
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                line_valid[s][w] = 1'b0;
            end
        end
    endfunction

    // way holding the tag, -1 when absent
    function automatic int find_way(input dcache_geom_pkg::set_idx_t set,
                                    input dcache_geom_pkg::tag_t tag);
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (line_valid[set][w] && line_tag[set][w] == tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic dcache_geom_pkg::word_t read_word(input dcache_geom_pkg::set_idx_t set,
                                                         input int way,
                                                         input dcache_geom_pkg::bank_idx_t bank);
        return line_data[set][way][bank];
    endfunction

    function automatic void fill_line(input dcache_geom_pkg::set_idx_t set, input int way,
                                      input dcache_geom_pkg::tag_t tag,
                                      input dcache_geom_pkg::line_t line);
        line_valid[set][way] = 1'b1;
        line_tag[set][way] = tag;
        line_data[set][way] = line;
    endfunction

    function automatic void merge_bytes(input dcache_geom_pkg::set_idx_t set, input int way,
                                        input dcache_geom_pkg::bank_idx_t bank,
                                        input dcache_geom_pkg::word_t data,
                                        input dcache_geom_pkg::byte_mask_t mask);
        for (int k = 0; k < dcache_geom_pkg::WORD_BYTES; k++) begin
            if (mask[k]) begin
                line_data[set][way][bank][8*k +: 8] = data[8*k +: 8];
            end
        end
    endfunction

endpackage

// File: verilog.f
+incdir+include
logic/dcache_geom_pkg.sv
logic/dcache_msg_pkg.sv
logic/load_bank_arbiter.sv
logic/load_pipe.sv
logic/load_result_collector.sv
logic/dcache_arrays.sv
logic/store_refill_ctrl.sv
logic/dcache_top.sv
sim/dcache_tb_model_pkg.sv
sim/dcache_tb.sv
